/* include/pooling_defs.svh */
`ifndef POOLING_DEFS_SVH
`define POOLING_DEFS_SVH

// width of one sample from the systolic array.
`define POOL_DATA_WIDTH 16

// number of output columns, one pooling lane each.
`define POOL_COLS 8

// windows per row, which is also the register file depth.
`define POOL_DEPTH 4

// enough bits to address POOL_DEPTH windows.
`define POOL_ADDR_WIDTH 2

`endif

/* hdl/pooling_pkg.sv */
`default_nettype none

package pooling_pkg;

    // ####################
    // opcodes
    // ####################

    // max keeps the larger operand, avg keeps the floor of the halved sum.
    typedef enum logic
    {
        POOL_MAX = 1'b0,
        POOL_AVG = 1'b1
    } pool_op_e;

    // ####################
    // controller states
    // ####################

    typedef enum logic [1:0]
    {
        IDLE  = 2'd0, // waiting for start.
        ROW0  = 2'd1, // first row of every window.
        ROW1  = 2'd2, // second row, results come out here.
        DRAIN = 2'd3  // skewed control still walking the columns.
    } pool_state_e;

endpackage

`default_nettype wire

/* hdl/pool_addr_counter.sv */
`default_nettype none

`include "pooling_defs.svh"

module pool_addr_counter
#(
    parameter int depth      = `POOL_DEPTH,
    parameter int addr_width = `POOL_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  clear,
    input  logic                  step,
    output logic [addr_width-1:0] adrs,
    output logic                  odd,
    output logic                  row_end
);

    // one row holds two elements per window, so the count needs one bit more.
    localparam int cnt_width = addr_width + 1;
    localparam logic [cnt_width-1:0] last_elem = cnt_width'(2 * depth - 1);

    logic [cnt_width-1:0] cnt;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            cnt <= '0;
        end
        else if (clear)
        begin
            cnt <= '0;
        end
        else if (step)
        begin
            // wrap at the end of a row so the next row starts at window 0.
            if (row_end)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
        end
    end

    assign adrs    = cnt[cnt_width-1:1]; // the pair index is the window address.
    assign odd     = cnt[0];             // second element of the pair.
    assign row_end = (cnt == last_elem);

endmodule

`default_nettype wire

/* hdl/pooling_control.sv */
`default_nettype none

`include "pooling_defs.svh"

module pooling_control
#(
    parameter int cols       = `POOL_COLS,
    parameter int depth      = `POOL_DEPTH,
    parameter int addr_width = `POOL_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  start,
    input  pooling_pkg::pool_op_e op_in,
    output logic [addr_width-1:0] adrs,
    output logic                  mux_sel,
    output logic                  wr_raw,
    output logic                  wr_pool,
    output logic                  cap,
    output logic                  pool_done,
    output logic                  last,
    output pooling_pkg::pool_op_e op,
    output logic                  busy
);

    import pooling_pkg::*;

    // the drain counter runs from 0 up to cols-2.
    localparam int drain_width = ($clog2(cols) > 0) ? $clog2(cols) : 1;
    localparam logic [drain_width-1:0] drain_last = drain_width'(cols - 2);

    pool_state_e            state;
    pool_state_e            state_next;
    pool_op_e               op_q;
    logic [drain_width-1:0] drain_cnt;
    logic                   odd;
    logic                   row_end;
    logic                   in_row;

    assign in_row = (state == ROW0) || (state == ROW1);

    pool_addr_counter
    #(
        .depth      (depth),
        .addr_width (addr_width)
    )
    addr_counter_i
    (
        .clk     (clk),
        .nrst    (nrst),
        .clear   (state == IDLE),
        .step    (in_row),
        .adrs    (adrs),
        .odd     (odd),
        .row_end (row_end)
    );

    // ####################
    // state machine
    // ####################

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:  if (start) state_next = ROW0;
            ROW0:  if (row_end) state_next = ROW1;
            ROW1:  if (row_end) state_next = (cols > 1) ? DRAIN : IDLE;
            DRAIN: if (drain_cnt == drain_last) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state     <= IDLE;
            op_q      <= POOL_MAX;
            drain_cnt <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == IDLE && start)
                op_q <= op_in; // the opcode holds for the whole job.
            if (state == DRAIN)
                drain_cnt <= drain_cnt + 1'b1;
            else
                drain_cnt <= '0;
        end
    end

    // ####################
    // column 0 strobes
    // ####################

    assign wr_raw    = (state == ROW0) && !odd;
    assign wr_pool   = (state == ROW0) && odd;
    assign cap       = (state == ROW1) && !odd;
    assign pool_done = (state == ROW1) && odd;
    assign last      = pool_done && row_end; // final window of the job.
    assign mux_sel   = (state == ROW0) || cap; // only the last fold uses the carry.
    assign op        = op_q;
    assign busy      = (state != IDLE);

endmodule

`default_nettype wire

/* hdl/regfile_pooling.sv */
`default_nettype none

`include "pooling_defs.svh"

module regfile_pooling
#(
    parameter int data_width = `POOL_DATA_WIDTH,
    parameter int depth      = `POOL_DEPTH,
    parameter int addr_width = `POOL_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  wr_raw,
    input  logic                  wr_pool,
    input  logic [data_width-1:0] raw_in,
    input  logic [data_width-1:0] pool_in,
    input  logic [addr_width-1:0] adrs,
    output logic [data_width-1:0] rd
);

    // one partial result per window of the current row.
    logic [data_width-1:0] mem [depth];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < depth; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (wr_pool)
        begin
            mem[adrs] <= pool_in; // folded value from the combiner.
        end
        else if (wr_raw)
        begin
            mem[adrs] <= raw_in; // first sample of a window.
        end
    end

    // The read is asynchronous so the combiner sees the entry in the same cycle.
    assign rd = mem[adrs];

endmodule

`default_nettype wire

/* hdl/pooling_lane.sv */
`default_nettype none

`include "pooling_defs.svh"

module pooling_lane
#(
    parameter int data_width = `POOL_DATA_WIDTH,
    parameter int depth      = `POOL_DEPTH,
    parameter int addr_width = `POOL_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [data_width-1:0] sys_out,
    input  logic [addr_width-1:0] adrs,
    input  logic                  mux_sel,
    input  logic                  wr_raw,
    input  logic                  wr_pool,
    input  logic                  cap,
    input  pooling_pkg::pool_op_e op,
    output logic [data_width-1:0] pooling_out
);

    import pooling_pkg::*;

    logic [data_width-1:0] rd;
    logic [data_width-1:0] operand_b;
    logic [data_width-1:0] carry;
    logic [data_width-1:0] max_val;
    logic [data_width-1:0] avg_val;
    logic [data_width:0]   sum;

    regfile_pooling
    #(
        .data_width (data_width),
        .depth      (depth),
        .addr_width (addr_width)
    )
    regfile_i
    (
        .clk     (clk),
        .nrst    (nrst),
        .wr_raw  (wr_raw),
        .wr_pool (wr_pool),
        .raw_in  (sys_out),
        .pool_in (pooling_out),
        .adrs    (adrs),
        .rd      (rd)
    );

    // ####################
    // combiner
    // ####################

    assign operand_b = mux_sel ? rd : carry;

    // The sum is one bit wider so the average of two large samples cannot wrap.
    assign sum     = {1'b0, sys_out} + {1'b0, operand_b};
    assign avg_val = sum[data_width:1]; // dropping the low bit rounds down.
    assign max_val = (sys_out > operand_b) ? sys_out : operand_b;

    assign pooling_out = (op == POOL_AVG) ? avg_val : max_val;

    // holds the fold of the row-1 even sample until its odd partner arrives.
    always_ff @(posedge clk)
    begin
        if (cap)
            carry <= pooling_out;
    end

endmodule

`default_nettype wire

/* hdl/pooling_skew_stage.sv */
`default_nettype none

`include "pooling_defs.svh"

module pooling_skew_stage
#(
    parameter int addr_width = `POOL_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [addr_width-1:0] in_adrs,
    input  logic                  in_mux_sel,
    input  logic                  in_wr_raw,
    input  logic                  in_wr_pool,
    input  logic                  in_cap,
    input  logic                  in_pool_done,
    input  logic                  in_last,
    input  pooling_pkg::pool_op_e in_op,
    output logic [addr_width-1:0] out_adrs,
    output logic                  out_mux_sel,
    output logic                  out_wr_raw,
    output logic                  out_wr_pool,
    output logic                  out_cap,
    output logic                  out_pool_done,
    output logic                  out_last,
    output pooling_pkg::pool_op_e out_op
);

    import pooling_pkg::*;

    // One cycle here matches the one cycle of skew between array columns.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            out_adrs      <= '0;
            out_mux_sel   <= 1'b0;
            out_wr_raw    <= 1'b0;
            out_wr_pool   <= 1'b0;
            out_cap       <= 1'b0;
            out_pool_done <= 1'b0;
            out_last      <= 1'b0;
            out_op        <= POOL_MAX;
        end
        else
        begin
            out_adrs      <= in_adrs;
            out_mux_sel   <= in_mux_sel;
            out_wr_raw    <= in_wr_raw;
            out_wr_pool   <= in_wr_pool;
            out_cap       <= in_cap;
            out_pool_done <= in_pool_done;
            out_last      <= in_last;
            out_op        <= in_op; // the opcode rides along with its strobes.
        end
    end

endmodule

`default_nettype wire

/* hdl/pooling_top.sv */
`default_nettype none

`include "pooling_defs.svh"

module pooling_top
#(
    parameter int data_width = `POOL_DATA_WIDTH,
    parameter int cols       = `POOL_COLS,
    parameter int depth      = `POOL_DEPTH,
    parameter int addr_width = `POOL_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  start,
    input  pooling_pkg::pool_op_e op_in,
    input  logic [data_width-1:0] sys_out      [cols],
    output logic [data_width-1:0] pooling_out  [cols],
    output logic                  pooling_done [cols],
    output logic                  pooling_finish,
    output logic                  busy
);

    import pooling_pkg::*;

    // control bundle, one copy per column.
    logic [addr_width-1:0] adrs      [cols];
    logic                  mux_sel   [cols];
    logic                  wr_raw    [cols];
    logic                  wr_pool   [cols];
    logic                  cap       [cols];
    logic                  pool_done [cols];
    logic                  last      [cols];
    pool_op_e              op        [cols];

    pooling_control
    #(
        .cols       (cols),
        .depth      (depth),
        .addr_width (addr_width)
    )
    control_i
    (
        .clk       (clk),
        .nrst      (nrst),
        .start     (start),
        .op_in     (op_in),
        .adrs      (adrs[0]),
        .mux_sel   (mux_sel[0]),
        .wr_raw    (wr_raw[0]),
        .wr_pool   (wr_pool[0]),
        .cap       (cap[0]),
        .pool_done (pool_done[0]),
        .last      (last[0]),
        .op        (op[0]),
        .busy      (busy)
    );

    // ####################
    // lanes
    // ####################

    for (genvar j = 0; j < cols; j++)
    begin : g_lane
        pooling_lane
        #(
            .data_width (data_width),
            .depth      (depth),
            .addr_width (addr_width)
        )
        lane_i
        (
            .clk         (clk),
            .nrst        (nrst),
            .sys_out     (sys_out[j]),
            .adrs        (adrs[j]),
            .mux_sel     (mux_sel[j]),
            .wr_raw      (wr_raw[j]),
            .wr_pool     (wr_pool[j]),
            .cap         (cap[j]),
            .op          (op[j]),
            .pooling_out (pooling_out[j])
        );

        assign pooling_done[j] = pool_done[j];
    end

    // ####################
    // skew chain
    // ####################

    for (genvar j = 1; j < cols; j++)
    begin : g_skew
        pooling_skew_stage
        #(
            .addr_width (addr_width)
        )
        skew_i
        (
            .clk           (clk),
            .nrst          (nrst),
            .in_adrs       (adrs[j-1]),
            .in_mux_sel    (mux_sel[j-1]),
            .in_wr_raw     (wr_raw[j-1]),
            .in_wr_pool    (wr_pool[j-1]),
            .in_cap        (cap[j-1]),
            .in_pool_done  (pool_done[j-1]),
            .in_last       (last[j-1]),
            .in_op         (op[j-1]),
            .out_adrs      (adrs[j]),
            .out_mux_sel   (mux_sel[j]),
            .out_wr_raw    (wr_raw[j]),
            .out_wr_pool   (wr_pool[j]),
            .out_cap       (cap[j]),
            .out_pool_done (pool_done[j]),
            .out_last      (last[j]),
            .out_op        (op[j])
        );
    end

    // The job is finished once the last column has put out its final window.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            pooling_finish <= 1'b0;
        else
            pooling_finish <= pool_done[cols-1] && last[cols-1];
    end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
#(
    parameter int period = 40
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0; // the first rising edge comes half a period in.
    end

    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

/* test/pooling_sva.sv */
`default_nettype none

`include "pooling_defs.svh"

module pooling_sva
#(
    parameter int cols = `POOL_COLS
)
(
    input logic clk,
    input logic nrst,
    input logic wr_raw       [cols],
    input logic wr_pool      [cols],
    input logic cap          [cols],
    input logic pooling_done [cols],
    input logic pooling_finish,
    input logic busy
);

    import pooling_pkg::*;

    int failures = 0; // number of failed assertions so far.

    for (genvar j = 0; j < cols; j++)
    begin : g_col
        // the register file takes one write source per cycle.
        a_one_write: assert property (@(posedge clk) disable iff (!nrst)
            !(wr_raw[j] && wr_pool[j]))
            else
            begin
                failures++;
                $error("column %0d wrote raw and pooled data in one cycle.", j);
            end

        a_done_in_job: assert property (@(posedge clk) disable iff (!nrst)
            !busy |-> !pooling_done[j])
            else
            begin
                failures++;
                $error("column %0d put out a window while the block was idle.", j);
            end

        a_reset_quiet: assert property (@(posedge clk)
            !nrst |-> !(wr_raw[j] || wr_pool[j] || cap[j] || pooling_done[j]))
            else
            begin
                failures++;
                $error("column %0d has a strobe high during reset.", j);
            end
    end

    a_reset_idle: assert property (@(posedge clk) !nrst |-> !(busy || pooling_finish))
        else
        begin
            failures++;
            $error("busy or pooling_finish is high during reset.");
        end

endmodule

bind pooling_top pooling_sva
#(
    .cols (cols)
)
sva_i
(
    .clk            (clk),
    .nrst           (nrst),
    .wr_raw         (wr_raw),
    .wr_pool        (wr_pool),
    .cap            (cap),
    .pooling_done   (pooling_done),
    .pooling_finish (pooling_finish),
    .busy           (busy)
);

`default_nettype wire

/* test/pooling_checker.sv */
`default_nettype none

`include "pooling_defs.svh"

module pooling_checker
#(
    parameter int data_width = `POOL_DATA_WIDTH,
    parameter int cols       = `POOL_COLS,
    parameter int depth      = `POOL_DEPTH
)
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [data_width-1:0] pooling_out  [cols],
    input  logic                  pooling_done [cols],
    input  logic                  pooling_finish,
    input  logic                  busy,
    output int                    error_count,
    output int                    finish_count
);

    import pooling_pkg::*;

    logic [data_width-1:0] exp_q [cols][$]; // expected windows, oldest first.
    int                    done_cnt   [cols];
    logic                  done0_hist [cols]; // entry k is pooling_done[0] from k+1 cycles back.
    logic                  finish_due;
    int                    errors   = 0;
    int                    finishes = 0;

    assign error_count  = errors;
    assign finish_count = finishes;

    task automatic expect_value(input int col, input logic [data_width-1:0] value);
        exp_q[col].push_back(value);
    endtask

    // Whatever is still queued here was never put out by the DUT.
    function automatic int count_leftovers();
        int total;
        total = 0;
        for (int j = 0; j < cols; j++)
        begin
            if (exp_q[j].size() != 0)
            begin
                $display("column %0d never produced %0d expected windows", j, exp_q[j].size());
                total += exp_q[j].size();
            end
        end
        return total;
    endfunction

    // ####################
    // per cycle checks
    // ####################

    always @(posedge clk)
    begin
        logic [data_width-1:0] expected;
        if (!nrst)
        begin
            for (int j = 0; j < cols; j++)
            begin
                done_cnt[j]   = 0;
                done0_hist[j] = 1'b0;
            end
            finish_due = 1'b0;
        end
        else
        begin
            for (int j = 0; j < cols; j++)
            begin
                if (pooling_done[j])
                begin
                    done_cnt[j]++;
                    if (exp_q[j].size() == 0)
                    begin
                        $display("column %0d gave a window when none was expected", j);
                        errors++;
                    end
                    else
                    begin
                        expected = exp_q[j].pop_front();
                        if (pooling_out[j] !== expected)
                        begin
                            $display("ERR pooling_out[%0d] got %h expected %h",
                                     j, pooling_out[j], expected);
                            errors++;
                        end
                    end
                end
                // column j runs exactly j cycles behind column 0.
                if (j > 0 && pooling_done[j] !== done0_hist[j-1])
                begin
                    $display("ERR pooling_done[%0d] got %h expected %h",
                             j, pooling_done[j], done0_hist[j-1]);
                    errors++;
                end
            end

            if (finish_due || pooling_finish)
            begin
                if (!pooling_finish)
                    $display("pooling_finish did not follow the last window of the job");
                else if (!finish_due)
                    $display("pooling_finish came before the last column was done");
                else if (busy !== 1'b0)
                    $display("ERR busy got %h expected %h", busy, 1'b0);
                if (!pooling_finish || !finish_due || busy !== 1'b0)
                    errors++;
                for (int j = 0; j < cols; j++)
                begin
                    if (done_cnt[j] != depth)
                    begin
                        $display("ERR pooling_done[%0d] pulse count got %h expected %h",
                                 j, done_cnt[j], depth);
                        errors++;
                    end
                    done_cnt[j] = 0;
                end
                if (pooling_finish)
                    finishes++;
            end

            finish_due = pooling_done[cols-1] && (done_cnt[cols-1] == depth);

            for (int k = cols - 1; k > 0; k--)
            begin
                done0_hist[k] = done0_hist[k-1];
            end
            done0_hist[0] = pooling_done[0];
        end
    end

endmodule

`default_nettype wire

/* test/pooling_tb.sv */
`default_nettype none

`include "pooling_defs.svh"

module pooling_tb;

    import pooling_pkg::*;

    localparam int data_width = `POOL_DATA_WIDTH;
    localparam int cols       = `POOL_COLS;
    localparam int depth      = `POOL_DEPTH;
    localparam int job_len    = 4 * depth; // two rows of two samples per window.
    localparam int num_jobs   = 6;
    localparam int max_cycles = 5 + num_jobs * (job_len + cols + 10);

    logic                  clk;
    logic                  nrst;
    logic                  start;
    pool_op_e              op_in;
    logic [data_width-1:0] sys_out      [cols];
    logic [data_width-1:0] pooling_out  [cols];
    logic                  pooling_done [cols];
    logic                  pooling_finish;
    logic                  busy;
    int                    checker_errors;
    int                    finish_count;
    int                    assert_errors;
    int                    errors;
    int                    leftovers;
    int                    cycles = 0;

    tb_clock_gen #(.period(40)) clock_gen_i (.clk(clk));

    pooling_top pooling_top_i
    (
        .clk            (clk),
        .nrst           (nrst),
        .start          (start),
        .op_in          (op_in),
        .sys_out        (sys_out),
        .pooling_out    (pooling_out),
        .pooling_done   (pooling_done),
        .pooling_finish (pooling_finish),
        .busy           (busy)
    );

    pooling_checker checker_i
    (
        .clk            (clk),
        .nrst           (nrst),
        .pooling_out    (pooling_out),
        .pooling_done   (pooling_done),
        .pooling_finish (pooling_finish),
        .busy           (busy),
        .error_count    (checker_errors),
        .finish_count   (finish_count)
    );

    // ####################
    // reference model
    // ####################

    function automatic logic [data_width-1:0] pool_pair(input pool_op_e op,
                                                        input logic [data_width-1:0] x,
                                                        input logic [data_width-1:0] y);
        int sum;
        sum = int'(x) + int'(y);
        if (op == POOL_AVG)
            return data_width'(sum / 2); // integer division rounds down for positive sums.
        return (x >= y) ? x : y;
    endfunction

    // window result is op(b1, op(b0, op(a1, a0))).
    function automatic logic [data_width-1:0] pool_ref(input pool_op_e op,
                                                       input logic [data_width-1:0] a0,
                                                       input logic [data_width-1:0] a1,
                                                       input logic [data_width-1:0] b0,
                                                       input logic [data_width-1:0] b1);
        return pool_pair(op, b1, pool_pair(op, b0, pool_pair(op, a1, a0)));
    endfunction

    // ####################
    // stimulus
    // ####################

    // Column j sees sample n at step n + j, so the data follows the array skew.
    task automatic run_job(input pool_op_e job_op, input bit high_range, input bit poke);
        logic [data_width-1:0] smp [cols][job_len];
        pool_op_e              other_op;
        int                    n;
        other_op = (job_op == POOL_MAX) ? POOL_AVG : POOL_MAX;
        for (int j = 0; j < cols; j++)
        begin
            for (int i = 0; i < job_len; i++)
            begin
                if (high_range)
                    smp[j][i] = ~data_width'($urandom % 16); // just below the top.
                else
                    smp[j][i] = data_width'($urandom);
            end
            for (int k = 0; k < depth; k++)
            begin
                checker_i.expect_value(j, pool_ref(job_op, smp[j][2*k], smp[j][2*k+1],
                                                   smp[j][2*depth+2*k],
                                                   smp[j][2*depth+2*k+1]));
            end
        end

        @(negedge clk);
        start = 1'b1;
        op_in = job_op;
        for (int t = 0; t < job_len + cols - 1; t++)
        begin
            @(negedge clk);
            start = poke && (t == 3); // lands while the job is running.
            op_in = other_op;
            for (int j = 0; j < cols; j++)
            begin
                n = t - j;
                if (n >= 0 && n < job_len)
                    sys_out[j] = smp[j][n];
                else
                    sys_out[j] = data_width'($urandom);
            end
        end
        do
            @(negedge clk);
        while (busy);
    endtask

    initial
    begin
        void'($urandom(37690));
        nrst  = 1'b0;
        start = 1'b0;
        op_in = POOL_MAX;
        for (int j = 0; j < cols; j++)
        begin
            sys_out[j] = '0;
        end
        repeat (5) @(negedge clk);
        nrst = 1'b1;

        run_job(POOL_MAX, 1'b0, 1'b0);
        run_job(POOL_AVG, 1'b1, 1'b0);
        run_job(POOL_MAX, 1'b0, 1'b1);
        run_job(POOL_AVG, 1'b0, 1'b1);
        run_job(POOL_MAX, 1'b1, 1'b0);
        run_job(POOL_AVG, 1'b0, 1'b0);
        repeat (3) @(negedge clk);

        leftovers     = checker_i.count_leftovers();
        assert_errors = pooling_top_i.sva_i.failures;
        errors        = checker_errors + assert_errors + leftovers;
        if (finish_count != num_jobs)
        begin
            $display("pooling_finish pulsed %0d times over %0d jobs", finish_count, num_jobs);
            errors++;
        end
        $display("errors: %0d from the checker, %0d from assertions, %0d windows missing, %0d in total",
                 checker_errors, assert_errors, leftovers, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("timeout after %0d cycles, the jobs did not complete", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hdl/pooling_pkg.sv
hdl/pool_addr_counter.sv
hdl/pooling_control.sv
hdl/regfile_pooling.sv
hdl/pooling_lane.sv
hdl/pooling_skew_stage.sv
hdl/pooling_top.sv
test/tb_clock_gen.sv
test/pooling_sva.sv
test/pooling_checker.sv
test/pooling_tb.sv
